// ==== all.f ====
cam_pkg.sv
sccb_init.sv
dvp_capture.sv
frame_buffer.sv
video_timing.sv
video_out.sv
camera_display.sv
tb_camera_display.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_camera_display
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_camera_display.sv ====
`timescale 1ns/100ps
module tb_camera_display;
	import cam_pkg::*;

	localparam int CLK_HALF       = 4;	// 8 ns period
	localparam int TIMEOUT_CYCLES = 12000;
	localparam int FRAMES         = 3;

	logic       clk;
	logic       reset;
	logic       cam_pclk;
	logic       cam_href;
	logic       cam_vsync;
	logic [7:0] cam_data;
	logic       cam_sioc;
	wire        cam_siod;
	logic       vga_hsync;
	logic       vga_vsync;
	logic       vga_de;
	logic [7:0] vga_r;
	logic [7:0] vga_g;
	logic [7:0] vga_b;

	pix565_u          model [FB_DEPTH];	// expected frame buffer contents
	integer           seed;
	int               cycles = 0;
	// sccb decoder state
	int               txn_count = 0;
	int               byte_idx = 0;
	int               phase_bit = 0;
	logic [7:0]       shreg = '0;
	logic [7:0]       exp_byte;
	logic             scl_p = 1'b1;
	logic             sda_p = 1'b1;
	// display monitor state
	logic             hs_p = 1'b1;
	logic             vs_p = 1'b1;
	logic             de_p = 1'b0;
	logic             hs_seen = 1'b0;
	int               line_de = 0;
	int               active_lines = 0;
	int               hs_len = 0;
	int               vs_len = 0;
	int               check_requests = 0;
	int               checks_started = 0;
	int               frames_checked = 0;
	logic             checking = 1'b0;
	logic             in_win;
	logic [FB_AW-1:0] fb_idx;
	pix565_u          exp_pix;

	pullup (cam_siod);

	always #CLK_HALF clk = ~clk;

	camera_display i_dut (
		.clk       (clk),
		.reset     (reset),
		.cam_pclk  (cam_pclk),
		.cam_href  (cam_href),
		.cam_vsync (cam_vsync),
		.cam_data  (cam_data),
		.cam_sioc  (cam_sioc),
		.cam_siod  (cam_siod),
		.vga_hsync (vga_hsync),
		.vga_vsync (vga_vsync),
		.vga_de    (vga_de),
		.vga_r     (vga_r),
		.vga_g     (vga_g),
		.vga_b     (vga_b)
	);

	// ----------------------------------------
	// checks
	task automatic abort_run;
		$display(">>> FAIL");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("ERROR %0t %s expected %h got %h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("ERROR %0t %s expected %0d got %0d", $time, name, exp, act);
			abort_run();
		end
	endtask

	// each channel widened by copying its top bits into the low bits
	function automatic logic [23:0] widen_565(input pix565_u p);
		return {p.rgb.r, p.rgb.r[4:2], p.rgb.g, p.rgb.g[5:4], p.rgb.b, p.rgb.b[4:2]};
	endfunction

	task automatic check_pixel(input int x, input int y, input pix565_u p,
	                           input logic [7:0] r, input logic [7:0] g, input logic [7:0] b);
		logic [23:0] exp;
		exp = widen_565(p);
		check_byte($sformatf("vga_r at x=%0d y=%0d", x, y), exp[23:16], r);
		check_byte($sformatf("vga_g at x=%0d y=%0d", x, y), exp[15:8], g);
		check_byte($sformatf("vga_b at x=%0d y=%0d", x, y), exp[7:0], b);
	endtask

	// ----------------------------------------
	// camera side
	task automatic pclk_period(input logic href, input logic vsync, input logic [7:0] data);
		@(posedge clk);
		cam_pclk  <= 1'b0;
		cam_href  <= href;
		cam_vsync <= vsync;
		cam_data  <= data;
		@(posedge clk);
		cam_pclk  <= 1'b1;	// sensor byte valid on this rise
	endtask

	task automatic send_frame(input int extra_cols, input int extra_rows, input bit keep);
		logic [7:0] hi;
		logic [7:0] lo;
		repeat (2) pclk_period(1'b0, 1'b1, 8'h00);	// vsync pulse
		pclk_period(1'b0, 1'b0, 8'h00);
		for (int r = 0; r < IMG_H + extra_rows; r++) begin
			for (int c = 0; c < IMG_W + extra_cols; c++) begin
				hi = 8'($random(seed));
				lo = 8'($random(seed));
				if (keep && r < IMG_H && c < IMG_W)
					model[FB_AW'(r * IMG_W + c)].raw = {hi, lo};	// high byte first
				pclk_period(1'b1, 1'b0, hi);
				pclk_period(1'b1, 1'b0, lo);
			end
			repeat (2) pclk_period(1'b0, 1'b0, 8'h00);	// line gap
		end
	endtask

	// ----------------------------------------
	// sccb decoder
	always @(negedge clk) begin
		if (!reset) begin
			if (scl_p && cam_sioc && sda_p && !cam_siod) begin	// start
				phase_bit = 0;
				byte_idx  = 0;
			end else if (scl_p && cam_sioc && !sda_p && cam_siod) begin	// stop
				check_count("sccb bytes per write", 3, byte_idx);
				txn_count++;
			end else if (!scl_p && cam_sioc) begin
				if (phase_bit < 8)
					shreg = {shreg[6:0], cam_siod};
				if (phase_bit == 8) begin	// ack slot ends the byte
					if (txn_count >= INIT_COUNT || byte_idx > 2) begin
						$display("more sccb traffic than the init table holds");
						abort_run();
					end
					case (byte_idx)
						0:       exp_byte = SCCB_ID;
						1:       exp_byte = INIT_TABLE[ENTRY_W'(txn_count)][15:8];
						default: exp_byte = INIT_TABLE[ENTRY_W'(txn_count)][7:0];
					endcase
					check_byte($sformatf("sccb write %0d byte %0d", txn_count, byte_idx),
					           exp_byte, shreg);
					byte_idx++;
					phase_bit = 0;
				end else begin
					phase_bit++;
				end
			end
			scl_p = cam_sioc;
			sda_p = cam_siod;
		end
	end

	// ----------------------------------------
	// display monitor
	always @(negedge clk) begin
		if (!reset) begin
			if (vga_de) begin
				if (checking) begin
					in_win = (line_de >= IMG_X) && (line_de < IMG_X + IMG_W) &&
					         (active_lines >= IMG_Y) && (active_lines < IMG_Y + IMG_H);
					if (in_win) begin
						fb_idx  = FB_AW'((active_lines - IMG_Y) * IMG_W + line_de - IMG_X);
						exp_pix = model[fb_idx];
					end else begin
						exp_pix = '0;	// black border
					end
					check_pixel(line_de, active_lines, exp_pix, vga_r, vga_g, vga_b);
				end
				line_de++;
			end
			if (de_p && !vga_de)
				active_lines++;
			if (hs_p && !vga_hsync) begin
				if (hs_seen && line_de != 0)	// line before the first pulse is partial
					check_count("vga_de cycles per line", H_ACTIVE, line_de);
				hs_seen = 1'b1;
				line_de = 0;
				hs_len  = 0;
			end
			if (!vga_hsync)
				hs_len++;
			if (!hs_p && vga_hsync)
				check_count("vga_hsync low cycles", H_SYNC, hs_len);
			if (vs_p && !vga_vsync) begin	// frame boundary
				check_count("vga_de lines per frame", V_ACTIVE, active_lines);
				active_lines = 0;
				vs_len       = 0;
				if (checking) begin
					checking = 1'b0;
					frames_checked++;
				end
				if (checks_started < check_requests) begin
					checking = 1'b1;
					checks_started++;
				end
			end
			if (!vga_vsync)
				vs_len++;
			if (!vs_p && vga_vsync)
				check_count("vga_vsync low cycles", V_SYNC * H_TOTAL, vs_len);
			hs_p = vga_hsync;
			vs_p = vga_vsync;
			de_p = vga_de;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
			abort_run();
		end
	end

	// ----------------------------------------
	// main sequence
	initial begin
		clk       = 1'b0;
		reset     = 1'b1;
		cam_pclk  = 1'b0;
		cam_href  = 1'b0;
		cam_vsync = 1'b0;
		cam_data  = 8'h00;
		seed      = 32'h4f31;
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		send_frame(0, 0, 1'b0);	// arrives while init is still running
		wait (txn_count == INIT_COUNT);
		repeat (2 * SCCB_DIV) @(posedge clk);	// ready follows the last stop

		for (int f = 0; f < FRAMES; f++) begin
			if (f == 1)
				send_frame(2, 1, 1'b1);	// oversized frame clipped by capture
			else
				send_frame(0, 0, 1'b1);
			check_requests++;
			wait (frames_checked == check_requests);
		end

		$display(">>> PASS");
		$finish;
	end

endmodule

// ==== camera_display.sv ====
`timescale 1ns/100ps
module camera_display (
	input  logic       clk,
	input  logic       reset,
	input  logic       cam_pclk,
	input  logic       cam_href,
	input  logic       cam_vsync,
	input  logic [7:0] cam_data,
	output logic       cam_sioc,
	inout  wire        cam_siod,
	output logic       vga_hsync,
	output logic       vga_vsync,
	output logic       vga_de,
	output logic [7:0] vga_r,
	output logic [7:0] vga_g,
	output logic [7:0] vga_b
);
	import cam_pkg::*;

	logic             sda_out;
	logic             sda_oe;
	logic             ready;
	logic             wr_en;
	logic [FB_AW-1:0] wr_addr;
	pix565_u          wr_data;
	logic             rd_en;
	logic [FB_AW-1:0] rd_addr;
	pix565_u          rd_data;
	logic             hsync;
	logic             vsync;
	logic             de;

	assign cam_siod = sda_oe ? sda_out : 1'bz;	// open bus, pulled up outside

	// ----------------------------------------
	// sensor side
	sccb_init u_sccb_init (
		.clk     (clk),
		.reset   (reset),
		.scl     (cam_sioc),
		.sda_out (sda_out),
		.sda_oe  (sda_oe),
		.ready   (ready)
	);

	dvp_capture u_dvp_capture (
		.clk       (clk),
		.reset     (reset),
		.ready     (ready),
		.cam_pclk  (cam_pclk),
		.cam_href  (cam_href),
		.cam_vsync (cam_vsync),
		.cam_data  (cam_data),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data)
	);

	frame_buffer u_frame_buffer (
		.clk     (clk),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	// display side
	video_timing u_video_timing (
		.clk     (clk),
		.reset   (reset),
		.hsync   (hsync),
		.vsync   (vsync),
		.de      (de),
		.rd_en   (rd_en),
		.rd_addr (rd_addr)
	);

	video_out u_video_out (
		.clk       (clk),
		.reset     (reset),
		.hsync     (hsync),
		.vsync     (vsync),
		.de        (de),
		.rd_en     (rd_en),
		.rd_data   (rd_data),
		.vga_hsync (vga_hsync),
		.vga_vsync (vga_vsync),
		.vga_de    (vga_de),
		.vga_r     (vga_r),
		.vga_g     (vga_g),
		.vga_b     (vga_b)
	);

endmodule

// ==== video_out.sv ====
`timescale 1ns/100ps
module video_out (
	input  logic             clk,
	input  logic             reset,
	input  logic             hsync,
	input  logic             vsync,
	input  logic             de,
	input  logic             rd_en,
	input  cam_pkg::pix565_u rd_data,
	output logic             vga_hsync,
	output logic             vga_vsync,
	output logic             vga_de,
	output logic [7:0]       vga_r,
	output logic [7:0]       vga_g,
	output logic [7:0]       vga_b
);
	logic hs_d;
	logic vs_d;
	logic de_d;
	logic rd_en_d;

	// ----------------------------------------
	// control delay to meet ram read data, then output stage
	always_ff @(posedge clk) begin
		if (reset) begin
			hs_d      <= 1'b1;
			vs_d      <= 1'b1;
			de_d      <= 1'b0;
			rd_en_d   <= 1'b0;
			vga_hsync <= 1'b1;
			vga_vsync <= 1'b1;
			vga_de    <= 1'b0;
		end else begin
			hs_d      <= hsync;
			vs_d      <= vsync;
			de_d      <= de;
			rd_en_d   <= rd_en;
			vga_hsync <= hs_d;
			vga_vsync <= vs_d;
			vga_de    <= de_d;
		end
	end

	// rgb565 -> rgb888, msbs replicated
	always_ff @(posedge clk) begin
		vga_r <= rd_en_d ? {rd_data.rgb.r, rd_data.rgb.r[4:2]} : 8'h00;
		vga_g <= rd_en_d ? {rd_data.rgb.g, rd_data.rgb.g[5:4]} : 8'h00;
		vga_b <= rd_en_d ? {rd_data.rgb.b, rd_data.rgb.b[4:2]} : 8'h00;	// black off window
	end

endmodule

// ==== video_timing.sv ====
`timescale 1ns/100ps
module video_timing (
	input  logic                      clk,
	input  logic                      reset,
	output logic                      hsync,
	output logic                      vsync,
	output logic                      de,
	output logic                      rd_en,
	output logic [cam_pkg::FB_AW-1:0] rd_addr
);
	import cam_pkg::*;

	logic [H_CW-1:0]  h_cnt;
	logic [V_CW-1:0]  v_cnt;
	logic [H_CW-1:0]  h_nxt;
	logic [V_CW-1:0]  v_nxt;
	logic             hs_nxt;
	logic             vs_nxt;
	logic             de_nxt;
	logic             in_win;
	logic [FB_AW-1:0] addr_nxt;

	// ----------------------------------------
	// counters
	always_comb begin
		h_nxt = h_cnt + 1'b1;
		v_nxt = v_cnt;
		if (h_cnt == H_CW'(H_TOTAL - 1)) begin
			h_nxt = '0;
			if (v_cnt == V_CW'(V_TOTAL - 1))
				v_nxt = '0;
			else
				v_nxt = v_cnt + 1'b1;
		end
	end

	// decode on the next count so outputs track the counter registers
	assign hs_nxt = !((h_nxt >= H_CW'(H_ACTIVE + H_FP)) &&
	                  (h_nxt < H_CW'(H_ACTIVE + H_FP + H_SYNC)));
	assign vs_nxt = !((v_nxt >= V_CW'(V_ACTIVE + V_FP)) &&
	                  (v_nxt < V_CW'(V_ACTIVE + V_FP + V_SYNC)));
	assign de_nxt = (h_nxt < H_CW'(H_ACTIVE)) && (v_nxt < V_CW'(V_ACTIVE));

	// image window inside the active area
	assign in_win = (h_nxt >= H_CW'(IMG_X)) && (h_nxt < H_CW'(IMG_X + IMG_W)) &&
	                (v_nxt >= V_CW'(IMG_Y)) && (v_nxt < V_CW'(IMG_Y + IMG_H));
	assign addr_nxt = FB_AW'((v_nxt - V_CW'(IMG_Y)) * IMG_W + (h_nxt - H_CW'(IMG_X)));

	always_ff @(posedge clk) begin
		if (reset) begin
			h_cnt <= '0;
			v_cnt <= '0;
			hsync <= 1'b1;
			vsync <= 1'b1;
			de    <= 1'b0;
			rd_en <= 1'b0;
		end else begin
			h_cnt <= h_nxt;
			v_cnt <= v_nxt;
			hsync <= hs_nxt;
			vsync <= vs_nxt;
			de    <= de_nxt;
			rd_en <= in_win;
		end
	end

	always_ff @(posedge clk) begin
		rd_addr <= addr_nxt;	// only meaningful with rd_en
	end

endmodule

// ==== frame_buffer.sv ====
`timescale 1ns/100ps
module frame_buffer (
	input  logic                      clk,
	input  logic                      wr_en,
	input  logic [cam_pkg::FB_AW-1:0] wr_addr,
	input  cam_pkg::pix565_u          wr_data,
	input  logic                      rd_en,
	input  logic [cam_pkg::FB_AW-1:0] rd_addr,
	output cam_pkg::pix565_u          rd_data
);
	import cam_pkg::*;

	logic [15:0] mem [FB_DEPTH];

	// camera side
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data.raw;
	end

	// display side, holds when idle
	always_ff @(posedge clk) begin
		if (rd_en)
			rd_data.raw <= mem[rd_addr];
	end

endmodule

// ==== dvp_capture.sv ====
`timescale 1ns/100ps
module dvp_capture (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      ready,
	input  logic                      cam_pclk,
	input  logic                      cam_href,
	input  logic                      cam_vsync,
	input  logic [7:0]                cam_data,
	output logic                      wr_en,
	output logic [cam_pkg::FB_AW-1:0] wr_addr,
	output cam_pkg::pix565_u          wr_data
);
	import cam_pkg::*;

	logic             pclk_q;
	logic             href_q;
	logic             vsync_q;
	logic             pclk_rise;
	logic             href_fall;
	logic             vsync_rise;
	logic             take;	// byte strobe
	logic             armed;
	logic             lo_phase;	// next byte is the low half
	logic [COL_W-1:0] col;
	logic [ROW_W-1:0] row;
	logic             in_window;

	assign pclk_rise  = !pclk_q && cam_pclk;
	assign href_fall  = href_q && !cam_href;
	assign vsync_rise = !vsync_q && cam_vsync;
	assign take       = pclk_rise && cam_href;
	assign in_window  = (col < COL_W'(IMG_W)) && (row < ROW_W'(IMG_H));

	always_ff @(posedge clk) begin
		if (reset) begin
			pclk_q   <= 1'b0;
			href_q   <= 1'b0;
			vsync_q  <= 1'b0;
			armed    <= 1'b0;
			lo_phase <= 1'b0;
			col      <= '0;
			row      <= '0;
			wr_en    <= 1'b0;
		end else begin
			pclk_q  <= cam_pclk;
			href_q  <= cam_href;
			vsync_q <= cam_vsync;
			wr_en   <= 1'b0;
			if (ready && vsync_rise)
				armed <= 1'b1;	// first full frame after init
			if (vsync_rise) begin
				col      <= '0;
				row      <= '0;
				lo_phase <= 1'b0;
			end else if (armed) begin
				if (href_fall) begin
					col      <= '0;
					lo_phase <= 1'b0;
					if (row < ROW_W'(IMG_H))
						row <= row + 1'b1;
				end else if (take) begin
					lo_phase <= !lo_phase;
					if (lo_phase) begin
						wr_en <= in_window;	// clip outside image size
						if (col < COL_W'(IMG_W))
							col <= col + 1'b1;
					end
				end
			end
		end
	end

	// pixel assembly
	always_ff @(posedge clk) begin
		if (take) begin
			if (lo_phase) begin
				wr_data.raw[7:0] <= cam_data;
				wr_addr          <= FB_AW'(row * IMG_W + col);
			end else begin
				wr_data.raw[15:8] <= cam_data;
			end
		end
	end

endmodule

// ==== sccb_init.sv ====
`timescale 1ns/100ps
module sccb_init (
	input  logic clk,
	input  logic reset,
	output logic scl,
	output logic sda_out,
	output logic sda_oe,
	output logic ready
);
	import cam_pkg::*;

	logic [SCCB_DW-1:0] div_cnt;
	logic               tick;
	logic [1:0]         q;	// quarter within a slot
	logic [SLOT_W-1:0]  slot;	// 0 start, 1..27 bits, 28 stop
	logic [3:0]         bit_cnt;
	logic [1:0]         byte_sel;
	logic [ENTRY_W-1:0] entry;
	logic [7:0]         cur_byte;
	logic               scl_d;
	logic               sda_d;
	logic               oe_d;

	assign tick = (div_cnt == SCCB_DW'(SCCB_DIV - 1));

	always_comb begin
		case (byte_sel)
			2'd0:    cur_byte = SCCB_ID;
			2'd1:    cur_byte = INIT_TABLE[entry][15:8];
			default: cur_byte = INIT_TABLE[entry][7:0];
		endcase
	end

	// ----------------------------------------
	// slot sequencer
	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt  <= '0;
			q        <= '0;
			slot     <= '0;
			bit_cnt  <= '0;
			byte_sel <= '0;
			entry    <= '0;
			ready    <= 1'b0;
		end else if (!ready) begin
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
			if (tick) begin
				q <= q + 1'b1;
				if (q == 2'd3) begin
					if (slot == SLOT_W'(SCCB_BITS + 1)) begin
						slot     <= '0;
						bit_cnt  <= '0;
						byte_sel <= '0;
						if (entry == ENTRY_W'(INIT_COUNT - 1))
							ready <= 1'b1;	// table done, stays high
						else
							entry <= entry + 1'b1;
					end else begin
						slot <= slot + 1'b1;
						if (slot != '0) begin
							if (bit_cnt == 4'd8) begin
								bit_cnt  <= '0;
								byte_sel <= byte_sel + 1'b1;
							end else begin
								bit_cnt <= bit_cnt + 1'b1;
							end
						end
					end
				end
			end
		end
	end

	// ----------------------------------------
	// line levels per slot and quarter
	always_comb begin
		scl_d = 1'b1;
		sda_d = 1'b1;
		oe_d  = 1'b0;
		if (!ready) begin
			oe_d = 1'b1;
			if (slot == '0) begin	// start, sda falls with scl high
				scl_d = (q != 2'd3);
				sda_d = (q == 2'd0);
			end else if (slot == SLOT_W'(SCCB_BITS + 1)) begin
				scl_d = (q != 2'd0);
				sda_d = 1'b0;
				oe_d  = (q != 2'd3);	// stop, sda rises via pull-up
			end else begin
				scl_d = (q == 2'd1) || (q == 2'd2);
				sda_d = cur_byte[3'd7 - bit_cnt[2:0]];	// msb first
				oe_d  = (bit_cnt != 4'd8);	// ninth bit belongs to sensor
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			scl     <= 1'b1;
			sda_out <= 1'b1;
			sda_oe  <= 1'b0;
		end else begin
			scl     <= scl_d;
			sda_out <= sda_d;
			sda_oe  <= oe_d;
		end
	end

endmodule

// ==== cam_pkg.sv ====
package cam_pkg;

	// ----------------------------------------
	// image window and frame buffer
	localparam int IMG_W    = 16;
	localparam int IMG_H    = 8;
	localparam int IMG_X    = 2;	// window offset, display coords
	localparam int IMG_Y    = 1;
	localparam int FB_DEPTH = IMG_W * IMG_H;
	localparam int FB_AW    = 7;
	localparam int COL_W    = $clog2(IMG_W + 1);	// room for the clip value
	localparam int ROW_W    = $clog2(IMG_H + 1);

	// ----------------------------------------
	// display timing, syncs active low
	localparam int H_ACTIVE = 24;
	localparam int H_FP     = 2;
	localparam int H_SYNC   = 4;
	localparam int H_BP     = 2;
	localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP;
	localparam int H_CW     = $clog2(H_TOTAL);
	localparam int V_ACTIVE = 12;
	localparam int V_FP     = 1;
	localparam int V_SYNC   = 2;
	localparam int V_BP     = 1;
	localparam int V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP;
	localparam int V_CW     = $clog2(V_TOTAL);

	// ----------------------------------------
	// sccb
	localparam int         SCCB_DIV   = 4;	// clk per quarter scl period
	localparam int         SCCB_DW    = $clog2(SCCB_DIV);
	localparam logic [7:0] SCCB_ID    = 8'h60;
	localparam int         SCCB_BITS  = 27;	// 3 x (8 data + 1 released)
	localparam int         SLOT_W     = $clog2(SCCB_BITS + 2);
	localparam int         INIT_COUNT = 4;
	localparam int         ENTRY_W    = $clog2(INIT_COUNT);

	// {register address, data}
	localparam logic [15:0] INIT_TABLE [INIT_COUNT] = '{
		16'hff01,	// sensor bank
		16'h1280,	// soft reset
		16'hff00,	// dsp bank
		16'hda08	// image mode rgb565
	};

	typedef union packed {
		logic [15:0] raw;	// sensor order, high byte first
		struct packed {
			logic [4:0] r;
			logic [5:0] g;
			logic [4:0] b;
		} rgb;
	} pix565_u;

endpackage
